//--- common/fpslice_pkg.sv
// Lanes 2 and 3 carry FP16 only, so FP32 vectors use two lanes
// Status fields follow the usual NV DZ OF UF NX order, MSB first
`default_nettype none

package fpslice_pkg;

  // ----------------------------------------
  // Sizes and constants
  // ----------------------------------------
  localparam int unsigned DATA_WIDTH  = 64;
  localparam int unsigned NUM_LANES   = 4;
  localparam int unsigned FP32_WIDTH  = 32;
  localparam int unsigned FP16_WIDTH  = 16;
  localparam int unsigned WIDE_LANES  = 2;  // Low lanes able to hold FP32
  localparam int unsigned TAG_BITS    = 4;
  localparam int unsigned PIPE_STAGES = 2;

  // Canonical quiet NaNs
  localparam logic [FP32_WIDTH-1:0] FP32_QNAN = 32'h7FC0_0000;
  localparam logic [FP16_WIDTH-1:0] FP16_QNAN = 16'h7E00;

  // ----------------------------------------
  // Opcodes and formats
  // ----------------------------------------
  typedef enum logic [2:0] {
    OP_MIN,
    OP_MAX,
    OP_SGNJ,   // Sign of b
    OP_SGNJN,  // Inverted sign of b
    OP_SGNJX   // Sign of a XOR b
  } op_e;

  typedef enum logic {
    FMT_FP32,
    FMT_FP16
  } fmt_e;

  // ----------------------------------------
  // Bundles
  // ----------------------------------------
  typedef struct packed {
    logic nv;  // Invalid operation
    logic dz;
    logic of;
    logic uf;
    logic nx;
  } status_t;

  typedef struct packed {
    logic [DATA_WIDTH-1:0] a;
    logic [DATA_WIDTH-1:0] b;
    op_e                   op;
    fmt_e                  fmt;
    logic                  vectorial;
    logic [TAG_BITS-1:0]   tag;
  } slice_req_t;

  // FP16 operands sit in the low half
  typedef struct packed {
    logic [FP32_WIDTH-1:0] a;
    logic [FP32_WIDTH-1:0] b;
  } lane_opnd_t;

  typedef struct packed {
    logic [FP32_WIDTH-1:0] result;
    status_t               status;
  } lane_rsp_t;

  typedef struct packed {
    lane_rsp_t [NUM_LANES-1:0] rsp;
    logic [NUM_LANES-1:0]      lane_mask;
    fmt_e                      fmt;
    logic                      vectorial;
    logic [TAG_BITS-1:0]       tag;
  } pipe_item_t;

  typedef struct packed {
    logic [DATA_WIDTH-1:0] result;
    status_t               status;
    logic [TAG_BITS-1:0]   tag;
  } slice_rsp_t;

endpackage

`default_nettype wire

//--- filelist.f
+incdir+sim
common/fpslice_pkg.sv
lanes/noncomp_lane.sv
lanes/lane_pipe.sv
logic/slice_issue.sv
logic/slice_pack.sv
logic/fp_slice_top.sv
sim/fp_slice_tb.sv

//--- lanes/lane_pipe.sv
// Elastic valid/ready stages; flush drops valid bits but leaves data
// Depth is PIPE_STAGES from the package
`default_nettype none
`timescale 1ns/10ps

module lane_pipe (
  input  logic                    clk_i,
  input  logic                    reset_i,
  input  logic                    flush_i,
  input  logic                    in_valid_i,
  output logic                    in_ready_o,
  input  fpslice_pkg::pipe_item_t item_i,
  output logic                    out_valid_o,
  input  logic                    out_ready_i,
  output fpslice_pkg::pipe_item_t item_o,
  output logic                    busy_o
);
  import fpslice_pkg::*;

  logic       [PIPE_STAGES-1:0] valid_q;
  pipe_item_t                   item_q  [PIPE_STAGES];
  logic       [PIPE_STAGES-1:0] valid_in;  // Feed into each stage
  pipe_item_t                   item_in [PIPE_STAGES];
  logic       [PIPE_STAGES:0]   ready;     // Stage s may load when ready[s]

  // ----------------------------------------
  // Stage inputs and backward ready
  // ----------------------------------------
  always_comb begin
    valid_in[0] = in_valid_i;
    item_in[0]  = item_i;
    for (int s = 1; s < PIPE_STAGES; s++) begin
      valid_in[s] = valid_q[s-1];
      item_in[s]  = item_q[s-1];
    end
  end

  // Advance if downstream takes the item or the stage holds a bubble
  always_comb begin
    ready[PIPE_STAGES] = out_ready_i;
    for (int s = PIPE_STAGES - 1; s >= 0; s--) begin
      ready[s] = ready[s+1] | ~valid_q[s];
    end
  end

  // ----------------------------------------
  // Registers
  // ----------------------------------------
  always_ff @(posedge clk_i) begin
    if (reset_i || flush_i) begin
      valid_q <= '0;
    end else begin
      for (int s = 0; s < PIPE_STAGES; s++) begin
        if (ready[s]) begin
          valid_q[s] <= valid_in[s];
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    for (int s = 0; s < PIPE_STAGES; s++) begin
      if (ready[s] && valid_in[s]) begin
        item_q[s] <= item_in[s];  // Load only real items
      end
    end
  end

  assign in_ready_o  = ready[0];
  assign out_valid_o = valid_q[PIPE_STAGES-1];
  assign item_o      = item_q[PIPE_STAGES-1];
  assign busy_o      = |valid_q;

endmodule

`default_nettype wire

//--- lanes/noncomp_lane.sv
// MIN/MAX use the minimumNumber rules; sign injection raises no flags
// With WideLane 0 an FP32 request is handled as FP16
`default_nettype none
`timescale 1ns/10ps

module noncomp_lane #(
  parameter bit WideLane = 1'b1
) (
  input  fpslice_pkg::lane_opnd_t opnd_i,
  input  fpslice_pkg::op_e        op_i,
  input  fpslice_pkg::fmt_e       fmt_i,
  output fpslice_pkg::lane_rsp_t  rsp_o
);
  import fpslice_pkg::*;

  logic                  is_fp32;
  logic                  is_minmax;
  logic                  sign_a, sign_b, res_sign;
  logic [FP32_WIDTH-1:0] mag_a, mag_b;
  logic                  nan_a, nan_b, snan_a, snan_b;
  logic                  a_lt_b;
  logic [FP32_WIDTH-1:0] qnan;
  logic [FP32_WIDTH-1:0] minmax_res, sgnj_res;

  // Returns {is NaN, is signaling NaN}
  function automatic logic [1:0] nan_class(input logic [FP32_WIDTH-1:0] v, input logic fp32);
    logic exp_ones;
    logic man_nz;
    logic quiet;
    exp_ones = fp32 ? &v[30:23] : &v[14:10];
    man_nz   = fp32 ? |v[22:0]  : |v[9:0];
    quiet    = fp32 ? v[22] : v[9];  // Top mantissa bit
    return {exp_ones & man_nz, exp_ones & man_nz & ~quiet};
  endfunction

  assign is_fp32   = WideLane && (fmt_i == FMT_FP32);
  assign is_minmax = (op_i == OP_MIN) || (op_i == OP_MAX);

  // ----------------------------------------
  // Operand classification
  // ----------------------------------------
  assign {nan_a, snan_a} = nan_class(opnd_i.a, is_fp32);
  assign {nan_b, snan_b} = nan_class(opnd_i.b, is_fp32);

  assign sign_a = is_fp32 ? opnd_i.a[31] : opnd_i.a[15];
  assign sign_b = is_fp32 ? opnd_i.b[31] : opnd_i.b[15];
  assign mag_a  = is_fp32 ? {1'b0, opnd_i.a[30:0]} : {17'h0, opnd_i.a[14:0]};
  assign mag_b  = is_fp32 ? {1'b0, opnd_i.b[30:0]} : {17'h0, opnd_i.b[14:0]};
  assign qnan   = is_fp32 ? FP32_QNAN : {{(FP32_WIDTH-FP16_WIDTH){1'b0}}, FP16_QNAN};

  // Sign-magnitude order, -0 falls below +0 through the sign test
  always_comb begin
    if (sign_a != sign_b) begin
      a_lt_b = sign_a;
    end else if (sign_a) begin
      a_lt_b = mag_a > mag_b;  // Both negative
    end else begin
      a_lt_b = mag_a < mag_b;
    end
  end

  // ----------------------------------------
  // Results
  // ----------------------------------------
  assign minmax_res = (nan_a && nan_b)              ? qnan     :
                      nan_a                         ? opnd_i.b :
                      nan_b                         ? opnd_i.a :
                      ((op_i == OP_MIN) == a_lt_b)  ? opnd_i.a : opnd_i.b;

  always_comb begin
    case (op_i)
      OP_SGNJN: res_sign = ~sign_b;
      OP_SGNJX: res_sign = sign_a ^ sign_b;
      default:  res_sign = sign_b;
    endcase
  end

  assign sgnj_res = is_fp32 ? {res_sign, opnd_i.a[30:0]} : {16'h0, res_sign, opnd_i.a[14:0]};

  always_comb begin
    rsp_o.result    = is_minmax ? minmax_res : sgnj_res;
    rsp_o.status    = '0;
    rsp_o.status.nv = is_minmax & (snan_a | snan_b);  // sNaN on either input
  end

endmodule

`default_nettype wire

//--- logic/fp_slice_top.sv
// Two-cycle latency with out_ready_i high, one request per cycle
// in_valid_i and in_req_i must hold until in_ready_o accepts them
`default_nettype none
`timescale 1ns/10ps

module fp_slice_top (
  input  logic                    clk_i,
  input  logic                    reset_i,
  input  logic                    flush_i,
  input  fpslice_pkg::slice_req_t in_req_i,
  input  logic                    in_valid_i,
  output logic                    in_ready_o,
  output fpslice_pkg::slice_rsp_t out_rsp_o,
  output logic                    out_valid_o,
  input  logic                    out_ready_i,
  output logic                    busy_o
);
  import fpslice_pkg::*;

  lane_opnd_t [NUM_LANES-1:0] lane_opnd;
  lane_rsp_t  [NUM_LANES-1:0] lane_rsp;
  logic       [NUM_LANES-1:0] lane_mask;
  pipe_item_t                 issue_item;
  pipe_item_t                 out_item;

  // ----------------------------------------
  // Issue and lanes
  // ----------------------------------------
  slice_issue i_issue (
    .req_i       (in_req_i),
    .lane_opnd_o (lane_opnd),
    .lane_mask_o (lane_mask)
  );

  for (genvar k = 0; k < NUM_LANES; k++) begin : gen_lanes
    noncomp_lane #(
      .WideLane (k < WIDE_LANES)  // Upper lanes are FP16 only
    ) i_lane (
      .opnd_i (lane_opnd[k]),
      .op_i   (in_req_i.op),
      .fmt_i  (in_req_i.fmt),
      .rsp_o  (lane_rsp[k])
    );
  end

  always_comb begin
    issue_item.rsp       = lane_rsp;
    issue_item.lane_mask = lane_mask;
    issue_item.fmt       = in_req_i.fmt;
    issue_item.vectorial = in_req_i.vectorial;
    issue_item.tag       = in_req_i.tag;
  end

  // ----------------------------------------
  // Pipeline and packing
  // ----------------------------------------
  lane_pipe i_pipe (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .flush_i     (flush_i),
    .in_valid_i  (in_valid_i),
    .in_ready_o  (in_ready_o),
    .item_i      (issue_item),
    .out_valid_o (out_valid_o),
    .out_ready_i (out_ready_i),
    .item_o      (out_item),
    .busy_o      (busy_o)
  );

  slice_pack i_pack (
    .item_i (out_item),
    .rsp_o  (out_rsp_o)
  );

endmodule

`default_nettype wire

//--- logic/slice_issue.sv
// Purely combinational; lanes beyond the operand width see zeros
`default_nettype none
`timescale 1ns/10ps

module slice_issue (
  input  fpslice_pkg::slice_req_t                              req_i,
  output fpslice_pkg::lane_opnd_t [fpslice_pkg::NUM_LANES-1:0] lane_opnd_o,
  output logic [fpslice_pkg::NUM_LANES-1:0]                    lane_mask_o
);
  import fpslice_pkg::*;

  logic is_fp16;

  assign is_fp16 = (req_i.fmt == FMT_FP16);

  // ----------------------------------------
  // Operand slicing
  // ----------------------------------------
  always_comb begin
    for (int k = 0; k < NUM_LANES; k++) begin
      if (is_fp16) begin
        // Half-width element in the low bits, upper half cleared
        lane_opnd_o[k].a = {{(FP32_WIDTH-FP16_WIDTH){1'b0}},
                            FP16_WIDTH'(req_i.a >> (k*FP16_WIDTH))};
        lane_opnd_o[k].b = {{(FP32_WIDTH-FP16_WIDTH){1'b0}},
                            FP16_WIDTH'(req_i.b >> (k*FP16_WIDTH))};
      end else begin
        lane_opnd_o[k].a = FP32_WIDTH'(req_i.a >> (k*FP32_WIDTH));
        lane_opnd_o[k].b = FP32_WIDTH'(req_i.b >> (k*FP32_WIDTH));
      end
    end
  end

  // ----------------------------------------
  // Lane-active mask
  // ----------------------------------------
  always_comb begin
    for (int k = 0; k < NUM_LANES; k++) begin
      if (k == 0) begin
        lane_mask_o[k] = 1'b1;  // Scalar always uses lane 0
      end else if (k < WIDE_LANES) begin
        lane_mask_o[k] = req_i.vectorial;
      end else begin
        lane_mask_o[k] = req_i.vectorial & is_fp16;  // Narrow lanes need FP16
      end
    end
  end

endmodule

`default_nettype wire

//--- logic/slice_pack.sv
// Bits not written by an active lane read as ones (NaN-boxing)
`default_nettype none
`timescale 1ns/10ps

module slice_pack (
  input  fpslice_pkg::pipe_item_t item_i,
  output fpslice_pkg::slice_rsp_t rsp_o
);
  import fpslice_pkg::*;

  logic [DATA_WIDTH-1:0] result;
  status_t               status;

  // ----------------------------------------
  // Lane placement and status collapse
  // ----------------------------------------
  always_comb begin
    result = '1;
    status = '0;
    for (int k = 0; k < NUM_LANES; k++) begin
      if (item_i.lane_mask[k]) begin
        status |= item_i.rsp[k].status;
        if (item_i.fmt == FMT_FP16) begin
          result[k*FP16_WIDTH +: FP16_WIDTH] = item_i.rsp[k].result[FP16_WIDTH-1:0];
        end else if (k < WIDE_LANES) begin
          result[k*FP32_WIDTH +: FP32_WIDTH] = item_i.rsp[k].result;  // FP32 lanes only
        end
      end
    end
  end

  assign rsp_o.result = result;
  assign rsp_o.status = status;
  assign rsp_o.tag    = item_i.tag;  // Tag rides along unchanged

endmodule

`default_nettype wire

//--- sim/fp_slice_vectors.svh
// Directed rows, included inside the testbench module body
// Some scalar rows put sNaN patterns in idle lanes, so a wrong lane mask shows up as NV
`ifndef FP_SLICE_VECTORS_SVH
`define FP_SLICE_VECTORS_SVH

localparam int NUM_ROWS = 18;

// Columns: op, format, vectorial, operand a, operand b, expected result, expected NV
task automatic load_rows();
  // ----------------------------------------
  // Scalar FP32, upper word NaN-boxed
  add_row(OP_MIN, FMT_FP32, 1'b0, 64'h7F800001_3F800000, 64'h00000000_40000000,
          64'hFFFFFFFF_3F800000, 1'b0);
  add_row(OP_MIN, FMT_FP32, 1'b0, 64'h12345678_00000000, 64'h9ABCDEF0_80000000,
          64'hFFFFFFFF_80000000, 1'b0);  // -0 below +0
  add_row(OP_MAX, FMT_FP32, 1'b0, 64'h00000000_00000000, 64'h00000000_80000000,
          64'hFFFFFFFF_00000000, 1'b0);
  add_row(OP_MIN, FMT_FP32, 1'b0, 64'h00000000_7FC00000, 64'h00000000_BF800000,
          64'hFFFFFFFF_BF800000, 1'b0);  // One quiet NaN
  add_row(OP_MAX, FMT_FP32, 1'b0, 64'h00000000_7FC00000, 64'h00000000_FFC00001,
          64'hFFFFFFFF_7FC00000, 1'b0);  // Two NaNs give the canonical NaN
  add_row(OP_MAX, FMT_FP32, 1'b0, 64'h00000000_3F800000, 64'h00000000_7F800001,
          64'hFFFFFFFF_3F800000, 1'b1);
  add_row(OP_MIN, FMT_FP32, 1'b0, 64'h00000000_C0000000, 64'h00000000_BF800000,
          64'hFFFFFFFF_C0000000, 1'b0);
  // Scalar FP16
  add_row(OP_MIN, FMT_FP16, 1'b0, 64'h7D00_7D00_7D00_3C00, 64'h0000_0000_0000_BC00,
          64'hFFFF_FFFF_FFFF_BC00, 1'b0);
  add_row(OP_MAX, FMT_FP16, 1'b0, 64'h0000_0000_0000_8000, 64'h0000_0000_0000_0000,
          64'hFFFF_FFFF_FFFF_0000, 1'b0);
  add_row(OP_MAX, FMT_FP16, 1'b0, 64'h0000_0000_0000_7D00, 64'h0000_0000_0000_4000,
          64'hFFFF_FFFF_FFFF_4000, 1'b1);  // Signaling NaN on a
  add_row(OP_MIN, FMT_FP16, 1'b0, 64'h0000_0000_0000_7E00, 64'h0000_0000_0000_FE01,
          64'hFFFF_FFFF_FFFF_7E00, 1'b0);
  // ----------------------------------------
  // Vector FP32, two lanes
  add_row(OP_MIN, FMT_FP32, 1'b1, 64'hBF800000_3F800000, 64'h3F800000_40000000,
          64'hBF800000_3F800000, 1'b0);
  add_row(OP_MAX, FMT_FP32, 1'b1, 64'h7F800001_00000000, 64'h40400000_80000000,
          64'h40400000_00000000, 1'b1);
  add_row(OP_SGNJ, FMT_FP32, 1'b1, 64'h3F800000_C0000000, 64'h80000000_00000000,
          64'hBF800000_40000000, 1'b0);
  // Vector FP16, four lanes
  add_row(OP_MIN, FMT_FP16, 1'b1, 64'h3C00_7E00_8000_C000, 64'h4000_3800_0000_BC00,
          64'h3C00_3800_8000_C000, 1'b0);
  add_row(OP_MAX, FMT_FP16, 1'b1, 64'h7C01_3C00_0000_FC00, 64'h3C00_7E00_8000_BC00,
          64'h3C00_3C00_0000_BC00, 1'b1);
  add_row(OP_SGNJN, FMT_FP16, 1'b1, 64'h3C00_BC00_4000_C000, 64'h0000_8000_8000_0000,
          64'hBC00_3C00_4000_C000, 1'b0);
  add_row(OP_SGNJX, FMT_FP16, 1'b1, 64'hBC00_3C00_BC00_3C00, 64'hBC00_BC00_3C00_3C00,
          64'h3C00_BC00_BC00_3C00, 1'b0);
endtask

`endif

//--- sim/fp_slice_tb.sv
// Directed rows with out_ready_i high, then a flush, then random sign injection
// under random back-pressure; stops at a cycle limit if results stop coming
`default_nettype none
`timescale 1ns/10ps

module fp_slice_tb;
  import fpslice_pkg::*;

  logic       clk_i;
  logic       reset_i;
  logic       flush_i;
  slice_req_t in_req_i;
  logic       in_valid_i;
  logic       in_ready_o;
  slice_rsp_t out_rsp_o;
  logic       out_valid_o;
  logic       out_ready_i;
  logic       busy_o;

  slice_req_t            row_req [$];
  logic [DATA_WIDTH-1:0] row_res [$];
  status_t               row_status [$];
  string                 exp_name_q [$];
  logic [DATA_WIDTH-1:0] exp_res_q [$];
  status_t               exp_stat_q [$];
  logic [TAG_BITS-1:0]   exp_tag_q [$];
  int unsigned           accept_q [$];  // Cycle of each accepted request

  int unsigned cycles = 0;
  int unsigned results = 0;
  int unsigned value_errors = 0;
  int unsigned other_errors = 0;
  logic        latency_check = 1'b0;
  logic        random_ready = 1'b0;
  logic [31:0] req_state = 32'd28620;
  logic [31:0] rdy_state;
  string       mon_name;
  int unsigned mon_acc;

  `include "fp_slice_vectors.svh"

  localparam int NUM_RANDOM  = 40;
  localparam int CYCLE_LIMIT = 20 * (NUM_ROWS + NUM_RANDOM) + 100;

  fp_slice_top dut0 (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .flush_i     (flush_i),
    .in_req_i    (in_req_i),
    .in_valid_i  (in_valid_i),
    .in_ready_o  (in_ready_o),
    .out_rsp_o   (out_rsp_o),
    .out_valid_o (out_valid_o),
    .out_ready_i (out_ready_i),
    .busy_o      (busy_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  // ----------------------------------------
  // Helpers
  // ----------------------------------------
  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic compare_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
    if (expected !== actual) begin
      $display("ERR %s: expected %h, actual %h", name, expected, actual);
      value_errors++;
    end
  endtask

  function automatic void add_row(input op_e op, input fmt_e fmt, input logic vec,
                                  input logic [63:0] a, input logic [63:0] b,
                                  input logic [63:0] res, input logic nv);
    slice_req_t req;
    status_t    st;
    req.a         = a;
    req.b         = b;
    req.op        = op;
    req.fmt       = fmt;
    req.vectorial = vec;
    req.tag       = TAG_BITS'(row_req.size());
    st            = '0;
    st.nv         = nv;
    row_req.push_back(req);
    row_res.push_back(res);
    row_status.push_back(st);
  endfunction

  function automatic logic injected_sign(input op_e op, input logic sa, input logic sb);
    if (op == OP_SGNJN) return ~sb;
    if (op == OP_SGNJX) return sa ^ sb;
    return sb;
  endfunction

  // Sign injection per active element, every other bit stays one
  function automatic logic [63:0] sgnj_expected(input slice_req_t req);
    logic [63:0] res;
    logic [31:0] wa, wb;
    logic [15:0] ha, hb;
    res = '1;
    for (int k = 0; k < 4; k++) begin
      if (req.fmt == FMT_FP32 && (k == 0 || (k == 1 && req.vectorial))) begin
        wa = req.a[k*32 +: 32];
        wb = req.b[k*32 +: 32];
        res[k*32 +: 32] = {injected_sign(req.op, wa[31], wb[31]), wa[30:0]};
      end else if (req.fmt == FMT_FP16 && (k == 0 || req.vectorial)) begin
        ha = req.a[k*16 +: 16];
        hb = req.b[k*16 +: 16];
        res[k*16 +: 16] = {injected_sign(req.op, ha[15], hb[15]), ha[14:0]};
      end
    end
    return res;
  endfunction

  task automatic random_request(input int idx, output slice_req_t req);
    logic [31:0] words [4];
    for (int w = 0; w < 4; w++) begin
      req_state = lcg_next(req_state);
      words[w]  = req_state;
    end
    req.a = {words[0], words[1]};
    req.b = {words[2], words[3]};
    case (req_state[25:24])
      2'd0:    req.op = OP_SGNJ;
      2'd1:    req.op = OP_SGNJN;
      default: req.op = OP_SGNJX;
    endcase
    req.fmt       = req_state[27] ? FMT_FP16 : FMT_FP32;
    req.vectorial = req_state[28];
    req.tag       = TAG_BITS'(idx);
  endtask

  // Called on a rising edge, returns on the edge where the request transfers
  task automatic issue_request(input slice_req_t req, input logic keep, input string name,
                               input logic [63:0] exp_res, input status_t exp_stat);
    in_req_i   <= req;
    in_valid_i <= 1'b1;
    if (keep) begin
      exp_name_q.push_back(name);
      exp_res_q.push_back(exp_res);
      exp_stat_q.push_back(exp_stat);
      exp_tag_q.push_back(req.tag);
    end
    @(posedge clk_i);
    while (!in_ready_o) @(posedge clk_i);
    if (keep) accept_q.push_back(cycles);
  endtask

  // Queue is checked between edges, after the monitor is done
  task automatic wait_drain();
    while (exp_res_q.size() != 0) @(negedge clk_i);
    @(posedge clk_i);
  endtask

  // ----------------------------------------
  // Cycle limit, ready stream, result monitor
  // ----------------------------------------
  always @(posedge clk_i) begin
    cycles <= cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      $display("Timeout: no end of test after %0d cycles, results still missing", cycles);
      $display("TEST RESULT: FAIL");
      $finish;
    end
  end

  always @(posedge clk_i) begin
    if (random_ready) begin
      rdy_state = lcg_next(rdy_state);
      out_ready_i <= rdy_state[16];
    end
  end

  always @(posedge clk_i) begin
    if (!reset_i && out_valid_o && out_ready_i) begin
      if (exp_res_q.size() == 0) begin
        $display("Result with tag %0h arrived with no request pending", out_rsp_o.tag);
        other_errors++;
      end else begin
        mon_name = exp_name_q.pop_front();
        compare_value({mon_name, " result"}, exp_res_q.pop_front(), out_rsp_o.result);
        compare_value({mon_name, " status"}, exp_stat_q.pop_front(), out_rsp_o.status);
        compare_value({mon_name, " tag"}, exp_tag_q.pop_front(), out_rsp_o.tag);
        mon_acc = accept_q.pop_front();
        if (latency_check) compare_value({mon_name, " latency"}, PIPE_STAGES, cycles - mon_acc);
        results++;
      end
    end
  end

  // ----------------------------------------
  // Test sequence
  // ----------------------------------------
  initial begin
    slice_req_t  req;
    int unsigned first_acc;
    reset_i     = 1'b1;
    flush_i     = 1'b0;
    in_req_i    = '0;
    in_valid_i  = 1'b0;
    out_ready_i = 1'b1;
    rdy_state   = lcg_next(32'd28620);
    first_acc   = 0;
    load_rows();
    repeat (8) @(posedge clk_i);
    reset_i <= 1'b0;
    @(posedge clk_i);
    compare_value("reset out_valid_o", 1'b0, out_valid_o);
    compare_value("reset busy_o", 1'b0, busy_o);
    compare_value("reset in_ready_o", 1'b1, in_ready_o);

    // Directed rows back to back, one accepted per cycle, fixed two-cycle latency
    latency_check = 1'b1;
    for (int i = 0; i < NUM_ROWS; i++) begin
      issue_request(row_req[i], 1'b1, $sformatf("row %0d", i), row_res[i], row_status[i]);
      if (i == 0) first_acc = accept_q[accept_q.size()-1];
      compare_value($sformatf("row %0d accept cycle", i), first_acc + i,
                    accept_q[accept_q.size()-1]);
    end
    in_valid_i <= 1'b0;
    wait_drain();
    latency_check = 1'b0;

    // Two items stalled in the pipe, then dropped by flush
    out_ready_i <= 1'b0;
    req = row_req[0];
    req.tag = 4'hE;
    issue_request(req, 1'b0, "", '0, '0);
    req.tag = 4'hF;
    issue_request(req, 1'b0, "", '0, '0);
    in_valid_i <= 1'b0;
    flush_i    <= 1'b1;
    @(posedge clk_i);
    compare_value("stall busy_o", 1'b1, busy_o);  // Both stages full
    compare_value("stall in_ready_o", 1'b0, in_ready_o);
    flush_i     <= 1'b0;
    out_ready_i <= 1'b1;
    @(posedge clk_i);
    compare_value("flush busy_o", 1'b0, busy_o);
    compare_value("flush out_valid_o", 1'b0, out_valid_o);
    req = row_req[1];
    req.tag = 4'hD;
    issue_request(req, 1'b1, "after flush", row_res[1], row_status[1]);
    in_valid_i <= 1'b0;
    wait_drain();

    // Random sign injection with random out_ready_i and idle gaps
    random_ready <= 1'b1;
    for (int i = 0; i < NUM_RANDOM; i++) begin
      random_request(i, req);
      issue_request(req, 1'b1, $sformatf("random %0d", i), sgnj_expected(req), '0);
      if (req_state[30]) begin
        in_valid_i <= 1'b0;
        @(posedge clk_i);
      end
    end
    in_valid_i <= 1'b0;
    wait_drain();
    random_ready = 1'b0;
    out_ready_i <= 1'b1;
    repeat (4) @(posedge clk_i);
    compare_value("result count", NUM_ROWS + NUM_RANDOM + 1, results);

    $display("Results %0d, value mismatches %0d, other errors %0d",
             results, value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire
